/* common/fetch_cfg.svh */
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch stage configuration
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// the first fetch after reset goes to this address outside the cached window.
`define FETCH_RESET_PC 32'h30000000

// the SDRAM window includes its base and excludes its limit.
// only fetches inside it go through the instruction cache.
`define SDRAM_BASE  32'ha0000000
`define SDRAM_LIMIT 32'ha2000000

// words per cache line and therefore beats per refill burst.
`define LINE_WORDS 4

// number of direct-mapped sets in the instruction cache.
`define ICACHE_SETS 16

`endif

/* common/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

	// fetch unit states.
	// lookup covers both the cache request and the wait for its response.
	typedef enum logic [2:0] {
		st_idle       = 3'd0,
		st_lookup     = 3'd1,
		st_refill_req = 3'd2,
		st_refill     = 3'd3,
		st_single     = 3'd4,
		st_deliver    = 3'd5
	} ifu_state_e;

	// burst kind on the memory read address channel.
	typedef enum logic [1:0] {
		burst_fixed = 2'd0,
		burst_incr  = 2'd1
	} burst_e;

	// the fetch unit looks only at bit 1 of the cache read response.
	typedef enum logic [1:0] {
		resp_hit  = 2'd0,
		resp_miss = 2'd2
	} cache_resp_e;

endpackage

`default_nettype wire

/* common/cache_port_if.sv */
`default_nettype none

// lookup and line-fill channels between the fetch unit and the instruction cache.
interface cache_port_if;

	// lookup channel.
	logic [31:0]            araddr;
	logic                   arvalid;
	logic                   arready;
	logic [31:0]            rdata;
	fetch_pkg::cache_resp_e rresp;
	logic                   rvalid;
	logic                   rready;

	// fill channel carrying one word per write.
	logic [31:0]            awaddr;
	logic                   awvalid;
	logic                   awready;
	logic [31:0]            wdata;
	logic                   wvalid;
	logic                   wready;
	logic                   bvalid;
	logic                   bready;

	modport fetch (
		output araddr, arvalid, rready,
		output awaddr, awvalid, wdata, wvalid, bready,
		input  arready, rdata, rresp, rvalid,
		input  awready, wready, bvalid
	);

	modport cache (
		input  araddr, arvalid, rready,
		input  awaddr, awvalid, wdata, wvalid, bready,
		output arready, rdata, rresp, rvalid,
		output awready, wready, bvalid
	);

endinterface

`default_nettype wire

/* fetch/ifu.sv */
`default_nettype none

`include "fetch_cfg.svh"

module ifu (
	input  logic              clock,
	input  logic              reset,

	output logic [31:0]       mem_araddr,
	output logic              mem_arvalid,
	input  logic              mem_arready,
	output fetch_pkg::burst_e mem_arburst,
	output logic [3:0]        mem_arlen,
	input  logic [31:0]       mem_rdata,
	input  logic              mem_rvalid,
	output logic              mem_rready,

	cache_port_if.fetch       cache,

	input  logic              wb_valid,
	input  logic [31:0]       jump_addr,
	output logic [31:0]       pc,
	output logic [31:0]       inst,
	output logic              idu_valid,
	input  logic              idu_ready
);

	localparam int          off_w     = $clog2(`LINE_WORDS) + 2;
	localparam int          cnt_w     = $clog2(`LINE_WORDS + 1);
	localparam logic [31:0] line_mask = ~((32'd1 << off_w) - 32'd1);

	function automatic logic in_sdram(input logic [31:0] addr);
		return (addr >= `SDRAM_BASE) && (addr < `SDRAM_LIMIT);
	endfunction

	fetch_pkg::ifu_state_e state;

	logic             go_q;
	logic             launch;
	logic [31:0]      fetch_addr;
	logic             pc_cached;
	logic             cache_arvalid;
	logic             fill_awvalid;
	logic             fill_wvalid;
	logic [31:0]      fill_addr;
	logic [31:0]      fill_data;
	logic [cnt_w-1:0] beats_left;
	logic             got_inst;
	logic             beat_fire;
	logic             lookup_done;
	logic             refill_done;
	logic             hand_off;
	logic             inst_load;
	logic [31:0]      inst_next;
	logic             idu_valid_next;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// request side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// a write-back strobe in idle starts the fetch right away with the new target.
	// otherwise go_q remembers that a fetch is owed, as it is after reset.
	assign launch     = (state == fetch_pkg::st_idle) & (wb_valid | go_q);
	assign fetch_addr = wb_valid ? jump_addr : pc;
	assign pc_cached  = in_sdram(pc);

	// refills start at the line boundary and always cover the whole line.
	assign mem_araddr  = pc_cached ? (pc & line_mask) : pc;
	assign mem_arburst = pc_cached ? fetch_pkg::burst_incr : fetch_pkg::burst_fixed;
	assign mem_arlen   = pc_cached ? 4'(`LINE_WORDS - 1) : 4'd0;

	assign cache.araddr  = pc;
	assign cache.arvalid = cache_arvalid;
	assign cache.rready  = 1'b1;
	assign cache.awaddr  = fill_addr;
	assign cache.awvalid = fill_awvalid;
	assign cache.wdata   = fill_data;
	assign cache.wvalid  = fill_wvalid;
	assign cache.bready  = 1'b1;

	assign beat_fire   = mem_rvalid & mem_rready;
	assign lookup_done = cache.rvalid & cache.rready;
	assign refill_done = cache.bvalid & cache.bready & (beats_left == cnt_w'(1));
	assign hand_off    = idu_valid & idu_ready;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// instruction capture
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// during a refill the wanted word is taken straight off the bus.
	// fill_addr always points at the word of the beat now arriving.
	always_comb begin
		inst_load = 1'b0;
		inst_next = mem_rdata;
		case (state)
			fetch_pkg::st_lookup: begin
				if (lookup_done & ~cache.rresp[1]) begin
					inst_load = 1'b1;
					inst_next = cache.rdata;
				end
			end
			fetch_pkg::st_single: begin
				inst_load = beat_fire;
			end
			fetch_pkg::st_refill: begin
				inst_load = beat_fire & ~got_inst &
					(fill_addr[off_w-1:2] == pc[off_w-1:2]);
			end
			default: begin
				inst_load = 1'b0;
			end
		endcase
	end

	assign idu_valid_next = inst_load | (idu_valid & ~idu_ready);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// fetch FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clock) begin
		if (reset) begin
			state         <= fetch_pkg::st_idle;
			pc            <= `FETCH_RESET_PC;
			go_q          <= 1'b1;
			cache_arvalid <= 1'b0;
			mem_arvalid   <= 1'b0;
			mem_rready    <= 1'b1;
			fill_awvalid  <= 1'b0;
			fill_wvalid   <= 1'b0;
			fill_addr     <= '0;
			beats_left    <= '0;
			got_inst      <= 1'b0;
			idu_valid     <= 1'b0;
		end else begin
			idu_valid <= idu_valid_next;

			if (wb_valid) begin
				pc <= jump_addr;
			end

			// a strobe that lands while a refill is still running is kept for later.
			if (launch) begin
				go_q <= 1'b0;
			end else if (wb_valid) begin
				go_q <= 1'b1;
			end

			case (state)
				fetch_pkg::st_idle: begin
					if (launch) begin
						if (in_sdram(fetch_addr)) begin
							state         <= fetch_pkg::st_lookup;
							cache_arvalid <= 1'b1;
						end else begin
							state       <= fetch_pkg::st_single;
							mem_arvalid <= 1'b1;
						end
					end
				end

				fetch_pkg::st_lookup: begin
					if (cache_arvalid & cache.arready) begin
						cache_arvalid <= 1'b0;
					end
					if (lookup_done) begin
						if (cache.rresp[1]) begin
							state       <= fetch_pkg::st_refill_req;
							mem_arvalid <= 1'b1;
							fill_addr   <= pc & line_mask;
							beats_left  <= cnt_w'(`LINE_WORDS);
							got_inst    <= 1'b0;
						end else begin
							state <= fetch_pkg::st_deliver;
						end
					end
				end

				fetch_pkg::st_refill_req: begin
					if (mem_arready) begin
						mem_arvalid <= 1'b0;
						state       <= fetch_pkg::st_refill;
					end
				end

				fetch_pkg::st_refill: begin
					if (fill_awvalid & cache.awready) begin
						fill_awvalid <= 1'b0;
					end
					if (fill_wvalid & cache.wready) begin
						fill_wvalid <= 1'b0;
					end
					// each beat is held off the bus until the cache has taken the word before.
					if (beat_fire) begin
						mem_rready   <= 1'b0;
						fill_awvalid <= 1'b1;
						fill_wvalid  <= 1'b1;
					end
					if (inst_load) begin
						got_inst <= 1'b1;
					end
					if (cache.bvalid & cache.bready) begin
						mem_rready <= 1'b1;
						fill_addr  <= fill_addr + 32'd4;
						beats_left <= beats_left - cnt_w'(1);
						if (refill_done) begin
							state <= idu_valid_next ? fetch_pkg::st_deliver : fetch_pkg::st_idle;
						end
					end
				end

				fetch_pkg::st_single: begin
					if (mem_arvalid & mem_arready) begin
						mem_arvalid <= 1'b0;
					end
					if (beat_fire) begin
						state <= fetch_pkg::st_deliver;
					end
				end

				fetch_pkg::st_deliver: begin
					if (hand_off) begin
						state <= fetch_pkg::st_idle;
					end
				end

				default: begin
					state <= fetch_pkg::st_idle;
				end
			endcase
		end
	end

	// instruction and fill word registers.
	always_ff @(posedge clock) begin
		if (inst_load) begin
			inst <= inst_next;
		end
		if (beat_fire && (state == fetch_pkg::st_refill)) begin
			fill_data <= mem_rdata;
		end
	end

endmodule

`default_nettype wire

/* icache/icache.sv */
`default_nettype none

`include "fetch_cfg.svh"

module icache #(
	parameter int sets = `ICACHE_SETS
) (
	input  logic        clock,
	input  logic        reset,
	cache_port_if.cache port
);

	localparam int word_w = $clog2(`LINE_WORDS);
	localparam int off_w  = word_w + 2;
	localparam int idx_w  = $clog2(sets);
	localparam int tag_w  = 32 - off_w - idx_w;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// storage
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	logic [tag_w-1:0] tag_mem  [sets];
	logic [31:0]      data_mem [sets * `LINE_WORDS];
	logic [sets-1:0]  valid_q;

	logic [idx_w-1:0]       rd_idx;
	logic [tag_w-1:0]       rd_tag;
	logic [word_w-1:0]      rd_word;
	logic                   rd_hit;
	logic                   ar_fire;
	logic                   rvalid_q;
	logic [31:0]            rdata_q;
	fetch_pkg::cache_resp_e rresp_q;

	logic              aw_got;
	logic              w_got;
	logic              aw_fire;
	logic              w_fire;
	logic [31:0]       aw_addr_q;
	logic [31:0]       w_data_q;
	logic              write_now;
	logic [idx_w-1:0]  wr_idx;
	logic [tag_w-1:0]  wr_tag;
	logic [word_w-1:0] wr_word;
	logic              wr_last;
	logic              bvalid_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// lookup
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign rd_idx  = port.araddr[off_w +: idx_w];
	assign rd_tag  = port.araddr[31 -: tag_w];
	assign rd_word = port.araddr[2 +: word_w];
	assign rd_hit  = valid_q[rd_idx] & (tag_mem[rd_idx] == rd_tag);

	// lookups are refused while a fill word sits half received.
	assign port.arready = ~(aw_got | w_got);
	assign ar_fire      = port.arvalid & port.arready;

	assign port.rvalid = rvalid_q;
	assign port.rdata  = rdata_q;
	assign port.rresp  = rresp_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// fill
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// address and data are taken independently, the write happens once both are in.
	assign port.awready = ~aw_got;
	assign port.wready  = ~w_got;
	assign aw_fire      = port.awvalid & port.awready;
	assign w_fire       = port.wvalid & port.wready;
	assign write_now    = aw_got & w_got;
	assign port.bvalid  = bvalid_q;

	assign wr_idx  = aw_addr_q[off_w +: idx_w];
	assign wr_tag  = aw_addr_q[31 -: tag_w];
	assign wr_word = aw_addr_q[2 +: word_w];
	assign wr_last = (wr_word == word_w'(`LINE_WORDS - 1));

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q  <= '0;
			aw_got   <= 1'b0;
			w_got    <= 1'b0;
			rvalid_q <= 1'b0;
			bvalid_q <= 1'b0;
		end else begin
			rvalid_q <= ar_fire | (rvalid_q & ~port.rready);
			bvalid_q <= write_now | (bvalid_q & ~port.bready);

			if (write_now) begin
				aw_got <= 1'b0;
				w_got  <= 1'b0;
				// a line is only valid again once its last word is in.
				valid_q[wr_idx] <= wr_last;
			end else begin
				if (aw_fire) begin
					aw_got <= 1'b1;
				end
				if (w_fire) begin
					w_got <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (aw_fire) begin
			aw_addr_q <= port.awaddr;
		end
		if (w_fire) begin
			w_data_q <= port.wdata;
		end
		if (write_now) begin
			data_mem[{wr_idx, wr_word}] <= w_data_q;
			if (wr_last) begin
				tag_mem[wr_idx] <= wr_tag;
			end
		end
		if (ar_fire) begin
			rdata_q <= data_mem[{rd_idx, rd_word}];
			rresp_q <= rd_hit ? fetch_pkg::resp_hit : fetch_pkg::resp_miss;
		end
	end

endmodule

`default_nettype wire

/* source/fetch_top.sv */
`default_nettype none

module fetch_top (
	input  logic              clock,
	input  logic              reset,

	// memory read bus
	output logic [31:0]       mem_araddr,
	output logic              mem_arvalid,
	input  logic              mem_arready,
	output fetch_pkg::burst_e mem_arburst,
	output logic [3:0]        mem_arlen,
	input  logic [31:0]       mem_rdata,
	input  logic              mem_rvalid,
	output logic              mem_rready,

	// write-back and decode side
	input  logic              wb_valid,
	input  logic [31:0]       jump_addr,
	output logic [31:0]       pc,
	output logic [31:0]       inst,
	output logic              idu_valid,
	input  logic              idu_ready
);

	cache_port_if cache_bus ();

	ifu u_ifu (
		.clock       (clock),
		.reset       (reset),
		.mem_araddr  (mem_araddr),
		.mem_arvalid (mem_arvalid),
		.mem_arready (mem_arready),
		.mem_arburst (mem_arburst),
		.mem_arlen   (mem_arlen),
		.mem_rdata   (mem_rdata),
		.mem_rvalid  (mem_rvalid),
		.mem_rready  (mem_rready),
		.cache       (cache_bus),
		.wb_valid    (wb_valid),
		.jump_addr   (jump_addr),
		.pc          (pc),
		.inst        (inst),
		.idu_valid   (idu_valid),
		.idu_ready   (idu_ready)
	);

	icache u_icache (
		.clock (clock),
		.reset (reset),
		.port  (cache_bus)
	);

endmodule

`default_nettype wire

/* verification/fetch_assert.sv */
`default_nettype none

// protocol checks on the memory read bus and the decode handshake.
module fetch_assert (
	input logic        clock,
	input logic        reset,
	input logic [31:0] mem_araddr,
	input logic        mem_arvalid,
	input logic        mem_arready,
	input logic [1:0]  mem_arburst,
	input logic [3:0]  mem_arlen,
	input logic [31:0] inst,
	input logic        idu_valid,
	input logic        idu_ready
);

	// a read request stays up with a stable payload until the slave takes it.
	ar_hold: assert property (@(posedge clock) disable iff (reset)
		mem_arvalid && !mem_arready |=>
			mem_arvalid && $stable(mem_araddr) && $stable(mem_arlen) && $stable(mem_arburst))
		else $error("read request dropped or changed before mem_arready");

	// decode sees the same instruction until it accepts it.
	inst_hold: assert property (@(posedge clock) disable iff (reset)
		idu_valid && !idu_ready |=> idu_valid && $stable(inst))
		else $error("instruction dropped or changed while decode stalled");

	// a held instruction blocks any new memory read.
	no_read_while_held: assert property (@(posedge clock) disable iff (reset)
		!(mem_arvalid && idu_valid))
		else $error("memory read issued while an instruction waits for decode");

endmodule

bind fetch_top fetch_assert u_assert (
	.clock       (clock),
	.reset       (reset),
	.mem_araddr  (mem_araddr),
	.mem_arvalid (mem_arvalid),
	.mem_arready (mem_arready),
	.mem_arburst (mem_arburst),
	.mem_arlen   (mem_arlen),
	.inst        (inst),
	.idu_valid   (idu_valid),
	.idu_ready   (idu_ready)
);

`default_nettype wire

/* verification/fetch_tb.sv */
`default_nettype none

`include "fetch_cfg.svh"

module fetch_tb;

	localparam int          fetch_total    = 400;
	localparam int          timeout_cycles = fetch_total * 40;
	localparam int          off_w          = $clog2(`LINE_WORDS * 4);
	localparam int          idx_w          = $clog2(`ICACHE_SETS);
	localparam logic [31:0] line_mask      = ~(32'(`LINE_WORDS * 4) - 32'd1);

	logic              clock = 1'b0;
	logic              reset;
	logic [31:0]       mem_araddr;
	logic              mem_arvalid;
	logic              mem_arready;
	fetch_pkg::burst_e mem_arburst;
	logic [3:0]        mem_arlen;
	logic [31:0]       mem_rdata;
	logic              mem_rvalid;
	logic              mem_rready;
	logic              wb_valid;
	logic [31:0]       jump_addr;
	logic [31:0]       pc;
	logic [31:0]       inst;
	logic              idu_valid;
	logic              idu_ready;

	// read requests as seen by the memory slave.
	int                ar_count = 0;
	logic [31:0]       last_araddr;
	logic [3:0]        last_arlen;
	fetch_pkg::burst_e last_arburst;

	int handshake_count = 0;
	int cycle_count     = 0;

	// tag and valid bit of each set as the cache should hold them.
	logic [31:0] model_tag   [`ICACHE_SETS];
	logic        model_valid [`ICACHE_SETS];

	fetch_top u_dut (
		.clock       (clock),
		.reset       (reset),
		.mem_araddr  (mem_araddr),
		.mem_arvalid (mem_arvalid),
		.mem_arready (mem_arready),
		.mem_arburst (mem_arburst),
		.mem_arlen   (mem_arlen),
		.mem_rdata   (mem_rdata),
		.mem_rvalid  (mem_rvalid),
		.mem_rready  (mem_rready),
		.wb_valid    (wb_valid),
		.jump_addr   (jump_addr),
		.pc          (pc),
		.inst        (inst),
		.idu_valid   (idu_valid),
		.idu_ready   (idu_ready)
	);

	always #50 clock = ~clock;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// the memory content is a fixed scramble of the word address.
	function automatic logic [31:0] word_hash(input logic [31:0] addr);
		return (addr * 32'h9e3779b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5bd1e995;
	endfunction

	function automatic bit in_window(input logic [31:0] addr);
		return (addr >= `SDRAM_BASE) && (addr < `SDRAM_LIMIT);
	endfunction

	// half the targets are uncached and the others use four tags over four sets.
	function automatic logic [31:0] pick_target(input logic [31:0] r);
		if (r[0]) begin
			return `FETCH_RESET_PC + {20'd0, r[11:2], 2'b00};
		end
		return `SDRAM_BASE + {18'd0, r[13:12], 6'd0, r[11:10], r[9:8], 2'b00};
	endfunction

	task automatic stop_on_failure(input string what);
		$display("%s", what);
		$display("Checks failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			stop_on_failure($sformatf("[ERROR] %s: expected 0x%08h, actual 0x%08h",
				name, expected, actual));
		end
	endtask

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > timeout_cycles) begin
			stop_on_failure($sformatf("timeout: fetches not done after %0d cycles", cycle_count));
		end
	end

	always @(posedge clock) begin
		if (!reset && idu_valid && idu_ready) begin
			handshake_count <= handshake_count + 1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// memory slave
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin : memory_slave
		logic [31:0] mem_rng;
		logic [31:0] beat_addr;
		// the slave draws its delays from a stream of its own.
		mem_rng = ~32'h24c3;
		forever begin
			@(negedge clock);
			if (!reset && mem_arvalid) begin
				ar_count     = ar_count + 1;
				last_araddr  = mem_araddr;
				last_arlen   = mem_arlen;
				last_arburst = mem_arburst;
				mem_rng = xorshift(mem_rng);
				repeat (mem_rng[1:0]) @(negedge clock);
				mem_arready = 1'b1;
				@(negedge clock);
				mem_arready = 1'b0;
				beat_addr = last_araddr;
				for (int b = 0; b <= int'(last_arlen); b++) begin
					mem_rng = xorshift(mem_rng);
					repeat (mem_rng[1:0]) @(negedge clock);
					mem_rdata  = word_hash(beat_addr);
					mem_rvalid = 1'b1;
					while (!mem_rready) @(negedge clock);
					@(negedge clock);
					mem_rvalid = 1'b0;
					if (last_arburst == fetch_pkg::burst_incr) begin
						beat_addr = beat_addr + 32'd4;
					end
				end
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// fetch sequence and reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin : main_flow
		logic [31:0] rng;
		logic [31:0] exp_pc;
		logic [31:0] exp_tag;
		logic [31:0] held_inst;
		logic [31:0] exp_reads;
		int          ar_before;
		int          idx;
		int          stall;
		int          linger;
		bit          cached;
		bit          hit;
		rng         = 32'h24c3;
		reset       = 1'b1;
		mem_arready = 1'b0;
		mem_rvalid  = 1'b0;
		mem_rdata   = 32'd0;
		wb_valid    = 1'b0;
		jump_addr   = 32'd0;
		idu_ready   = 1'b0;
		for (int s = 0; s < `ICACHE_SETS; s++) begin
			model_valid[s] = 1'b0;
			model_tag[s]   = 32'd0;
		end
		repeat (10) @(negedge clock);
		reset     = 1'b0;
		exp_pc    = `FETCH_RESET_PC;
		ar_before = 0;

		for (int n = 0; n < fetch_total; n++) begin
			cached  = in_window(exp_pc);
			idx     = int'(exp_pc[off_w +: idx_w]);
			exp_tag = exp_pc >> (off_w + idx_w);
			hit     = cached && model_valid[idx] && (model_tag[idx] == exp_tag);
			// a miss refills the whole line and replaces whatever the set held.
			if (cached && !hit) begin
				model_valid[idx] = 1'b1;
				model_tag[idx]   = exp_tag;
			end
			exp_reads = hit ? 32'd0 : 32'd1;

			do @(negedge clock); while (!idu_valid);
			held_inst = inst;
			check_value("pc", exp_pc, pc);
			check_value("inst", word_hash(exp_pc), inst);
			check_value("read count", exp_reads, 32'(ar_count - ar_before));
			if (!cached) begin
				check_value("mem_araddr", exp_pc, last_araddr);
				check_value("mem_arlen", 32'd0, {28'd0, last_arlen});
				check_value("mem_arburst", 32'(fetch_pkg::burst_fixed), 32'(last_arburst));
			end else if (!hit) begin
				check_value("mem_araddr", exp_pc & line_mask, last_araddr);
				check_value("mem_arlen", 32'(`LINE_WORDS - 1), {28'd0, last_arlen});
				check_value("mem_arburst", 32'(fetch_pkg::burst_incr), 32'(last_arburst));
			end

			// decode stalls for a random span before taking the instruction.
			rng    = xorshift(rng);
			stall  = int'(rng[2:0]);
			linger = int'(rng[4:3]);
			repeat (stall) begin
				@(negedge clock);
				check_value("idu_valid", 32'd1, {31'd0, idu_valid});
				check_value("inst", held_inst, inst);
			end
			idu_ready = 1'b1;
			@(negedge clock);
			check_value("idu_valid", 32'd0, {31'd0, idu_valid});
			// decode may stay ready a few cycles longer without a second instruction appearing.
			repeat (linger) @(negedge clock);
			idu_ready = 1'b0;
			check_value("handshakes", 32'(n + 1), 32'(handshake_count));
			check_value("read count", exp_reads, 32'(ar_count - ar_before));

			if (n < fetch_total - 1) begin
				rng       = xorshift(rng);
				exp_pc    = pick_target(rng);
				ar_before = ar_count;
				jump_addr = exp_pc;
				wb_valid  = 1'b1;
				@(negedge clock);
				wb_valid = 1'b0;
			end
		end

		@(negedge clock);
		check_value("handshakes", 32'(fetch_total), 32'(handshake_count));
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
+incdir+common
common/fetch_pkg.sv
common/cache_port_if.sv
fetch/ifu.sv
icache/icache.sv
source/fetch_top.sv
verification/fetch_assert.sv
verification/fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the fetch stage testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module fetch_tb \
	-Mdir obj_dir \
	-f all.f

./obj_dir/Vfetch_tb 2>&1 | tee sim.log

if grep -qxF "All checks passed" sim.log; then
	echo "simulation result: pass"
else
	echo "simulation result: fail"
	exit 1
fi
